// ==== build.f ====
+incdir+include
src/poker_money_pkg.sv
src/poker_flow_pkg.sv
src/chip_bank.sv
src/bet_sizer.sv
src/turn_tracker.sv
src/betting_control.sv
src/poker_table.sv
tb/poker_table_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the log holds the pass line
verilator --binary --timing --assert --timescale 1ns/1ps --top-module poker_table_tb \
	-f build.f > build.log 2>&1 &&
./obj_dir/Vpoker_table_tb > sim.log 2>&1 ;
cat sim.log ;
grep -qx "Test OK" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed, see build.log and sim.log" ; exit 1 ; }

// ==== src/bet_sizer.sv ====
// Action to chip amount conversion with call demotion and all-in cap
`timescale 1ns/1ps
`default_nettype none

module bet_sizer import poker_money_pkg::*, poker_flow_pkg::*;
(
	input action_t action,
	input seat_t to_act,
	input chip_t stack0,
	input chip_t stack1,
	input chip_t bet0,
	input chip_t bet1,
	output chip_t bet_amount,	// Chips moved from actor stack to bet
	output logic raised	// Opponent must respond
);

	chip_t own_stack, own_bet, opp_stack, opp_bet;
	chip_t own_total, opp_total, cap;	// Bet plus stack per seat
	chip_t call_amount;
	chip_t target;	// Raise level in chips
	logic raise_ok;

	// Actor and opponent view
	assign own_stack = to_act ? stack1 : stack0;
	assign own_bet = to_act ? bet1 : bet0;
	assign opp_stack = to_act ? stack0 : stack1;
	assign opp_bet = to_act ? bet0 : bet1;

	assign own_total = own_bet + own_stack;
	assign opp_total = opp_bet + opp_stack;
	assign cap = (own_total < opp_total) ? own_total : opp_total;

	// Shortfall, limited by what is left
	assign call_amount = (opp_bet <= own_bet) ? '0 :
		((opp_bet - own_bet) < own_stack) ? (opp_bet - own_bet) : own_stack;

	always_comb
	begin
		case (action)
			ACT_RAISE_2BB: target = chip_t'(2 * BIG_BLIND);
			ACT_RAISE_4BB: target = chip_t'(4 * BIG_BLIND);
			ACT_RAISE_6BB: target = chip_t'(6 * BIG_BLIND);
			default: target = '0;
		endcase
	end

	// Level must be above both bets and covered by both seats
	assign raise_ok = (target > own_bet) && (target > opp_bet) &&
		(own_total >= target) && (opp_total >= target);

	always_comb
	begin
		bet_amount = call_amount;	// Check and call alike
		raised = 1'b0;
		case (action)
			ACT_RAISE_2BB, ACT_RAISE_4BB, ACT_RAISE_6BB:
				if (raise_ok)	// Else stays a call
				begin
					bet_amount = target - own_bet;
					raised = 1'b1;
				end
			ACT_ALL_IN:
			begin
				bet_amount = (cap > own_bet) ? (cap - own_bet) : '0;
				raised = (cap > opp_bet);
			end
			ACT_FOLD: bet_amount = '0;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/betting_control.sv ====
// Hand and street sequencing FSM with action and showdown handshakes
`timescale 1ns/1ps
`default_nettype none

module betting_control import poker_money_pkg::*, poker_flow_pkg::*;
(
	input logic clock,
	input logic resetn,
	input logic start,
	input logic action_valid,
	input action_t action,
	input logic showdown_valid,
	input winner_t showdown_winner,
	input logic raised,
	input logic round_done,
	input street_t street,
	input seat_t to_act,
	input chip_t stack0,
	input chip_t stack1,
	output logic action_ready,
	output logic showdown_ready,
	output logic reset_chips,
	output logic post_blinds,
	output logic add_bet,
	output logic collect,
	output logic award,
	output winner_t award_result,
	output logic new_hand,
	output logic new_street,
	output logic acted,
	output logic hand_over,
	output logic match_over,
	output seat_t match_winner
);

	ctrl_state_t state, next_state;
	winner_t result_q;	// Fold or showdown outcome
	logic empty_stack;
	logic take_action;	// Action handshake
	logic take_result;	// Showdown handshake
	logic is_fold;

	assign empty_stack = (stack0 == '0) || (stack1 == '0);
	assign take_action = action_ready && action_valid;
	assign take_result = showdown_ready && showdown_valid;
	assign is_fold = (action == ACT_FOLD);

	// Next state
	always_comb
	begin
		next_state = state;
		case (state)
			CS_IDLE, CS_MATCH_OVER:
				if (start)
					next_state = CS_RESET;
			CS_RESET: next_state = CS_NEW_HAND;
			CS_NEW_HAND: next_state = empty_stack ? CS_MATCH_OVER : CS_BLINDS;
			CS_BLINDS: next_state = CS_WAIT_ACTION;
			CS_WAIT_ACTION:
				if (take_action)
				begin
					if (is_fold)
						next_state = CS_AWARD;
					else if (round_done && !raised)	// Nobody left to act
						next_state = CS_STREET_END;
					else
						next_state = CS_APPLY;
				end
			CS_APPLY: next_state = CS_WAIT_ACTION;	// Turn passes over
			CS_STREET_END: next_state = (street == ST_RIVER) ? CS_SHOWDOWN : CS_WAIT_ACTION;
			CS_SHOWDOWN:
				if (take_result)
					next_state = CS_AWARD;
			CS_AWARD: next_state = CS_HAND_DONE;
			CS_HAND_DONE: next_state = CS_NEW_HAND;
			default: next_state = CS_IDLE;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			state <= CS_IDLE;
			result_q <= WIN_TIE;
			match_winner <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (take_action && is_fold)	// Other seat takes it all
				result_q <= to_act ? WIN_SEAT0 : WIN_SEAT1;
			else if (take_result)
				result_q <= showdown_winner;
			if (state == CS_NEW_HAND && empty_stack)
				match_winner <= seat_t'(stack0 == '0);	// Seat still holding chips
		end
	end

	// Handshakes
	assign action_ready = (state == CS_WAIT_ACTION);
	assign showdown_ready = (state == CS_SHOWDOWN);

	// Datapath strobes
	assign reset_chips = (state == CS_RESET);
	assign post_blinds = (state == CS_BLINDS);
	assign add_bet = take_action && !is_fold;
	assign collect = (state == CS_STREET_END);
	assign award = (state == CS_AWARD);
	assign award_result = result_q;

	// Turn strobes, new_hand with new_street on match start
	assign new_hand = (state == CS_RESET) || (state == CS_NEW_HAND && !empty_stack);
	assign new_street = (state == CS_RESET) || (state == CS_STREET_END);
	assign acted = take_action && !is_fold;

	// Status
	assign hand_over = (state == CS_HAND_DONE);
	assign match_over = (state == CS_MATCH_OVER);

endmodule

`default_nettype wire

// ==== src/chip_bank.sv ====
// Stack, bet and pot registers with blind posting, betting, collection and award
`timescale 1ns/1ps
`default_nettype none

module chip_bank import poker_money_pkg::*, poker_flow_pkg::*;
#(
	parameter chip_t START_CHIPS = 15'd2000
)
(
	input logic clock,
	input logic resetn,
	input logic reset_chips,	// Fresh match
	input logic post_blinds,
	input seat_t big_blind_seat,
	input logic add_bet,
	input seat_t bet_seat,
	input chip_t bet_amount,
	input logic collect,	// Bets into pot
	input logic award,
	input winner_t award_result,
	output chip_t stack0,
	output chip_t stack1,
	output chip_t bet0,
	output chip_t bet1,
	output chip_t pot
);

	chip_t big_stack, small_stack;	// Stacks of the blind seats
	chip_t big_post, small_post;	// Blinds capped at stacks
	chip_t blind0, blind1;	// Blind per seat
	chip_t total;	// Everything on the table
	chip_t half;	// Seat 1 share of a split

	assign big_stack = big_blind_seat ? stack1 : stack0;
	assign small_stack = big_blind_seat ? stack0 : stack1;
	assign big_post = (big_stack < BIG_BLIND) ? big_stack : BIG_BLIND;
	assign small_post = (small_stack < SMALL_BLIND) ? small_stack : SMALL_BLIND;
	assign blind0 = big_blind_seat ? small_post : big_post;
	assign blind1 = big_blind_seat ? big_post : small_post;

	assign total = pot + bet0 + bet1;
	assign half = total >> 1;	// Rounds down, odd chip stays with seat 0

	always_ff @(posedge clock)
	begin
		if (!resetn)	// Empty table until start
		begin
			stack0 <= '0;
			stack1 <= '0;
			bet0 <= '0;
			bet1 <= '0;
			pot <= '0;
		end
		else if (reset_chips)
		begin
			stack0 <= START_CHIPS;
			stack1 <= START_CHIPS;
			bet0 <= '0;
			bet1 <= '0;
			pot <= '0;
		end
		else if (post_blinds)	// Bets are empty at hand start
		begin
			stack0 <= stack0 - blind0;
			stack1 <= stack1 - blind1;
			bet0 <= bet0 + blind0;
			bet1 <= bet1 + blind1;
		end
		else if (add_bet)	// Stack to bet of acting seat
		begin
			if (bet_seat)
			begin
				stack1 <= stack1 - bet_amount;
				bet1 <= bet1 + bet_amount;
			end
			else
			begin
				stack0 <= stack0 - bet_amount;
				bet0 <= bet0 + bet_amount;
			end
		end
		else if (collect)
		begin
			pot <= total;
			bet0 <= '0;
			bet1 <= '0;
		end
		else if (award)	// Bets gathered and paid out in one step
		begin
			pot <= '0;
			bet0 <= '0;
			bet1 <= '0;
			case (award_result)
				WIN_SEAT0: stack0 <= stack0 + total;
				WIN_SEAT1: stack1 <= stack1 + total;
				default:	// Split pot
				begin
					stack0 <= stack0 + (total - half);
					stack1 <= stack1 + half;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/poker_flow_pkg.sv ====
// Action, street, winner and control state encodings
`default_nettype none

package poker_flow_pkg;

	// Action codes from the host
	typedef enum logic [2:0] {
		ACT_CHECK = 3'd0,
		ACT_CALL = 3'd1,
		ACT_RAISE_2BB = 3'd2,
		ACT_RAISE_4BB = 3'd3,
		ACT_RAISE_6BB = 3'd4,
		ACT_ALL_IN = 3'd5,
		ACT_FOLD = 3'd6
	} action_t;

	// Betting rounds of one hand
	typedef enum logic [2:0] {
		ST_PREFLOP = 3'd0,
		ST_FLOP = 3'd1,
		ST_TURN = 3'd2,
		ST_RIVER = 3'd3,
		ST_SHOWDOWN = 3'd4
	} street_t;

	// Pot award result
	typedef enum logic [1:0] {
		WIN_TIE = 2'd0,
		WIN_SEAT0 = 2'd1,
		WIN_SEAT1 = 2'd2
	} winner_t;

	// Hand sequencing FSM
	typedef enum logic [3:0] {
		CS_IDLE,
		CS_RESET,
		CS_NEW_HAND,
		CS_BLINDS,
		CS_WAIT_ACTION,
		CS_APPLY,
		CS_STREET_END,
		CS_SHOWDOWN,
		CS_AWARD,
		CS_HAND_DONE,
		CS_MATCH_OVER
	} ctrl_state_t;

endpackage

`default_nettype wire

// ==== src/poker_money_pkg.sv ====
// Chip amount and seat types, blind values
`default_nettype none

package poker_money_pkg;

	typedef logic [14:0] chip_t;	// Chip amount
	typedef logic seat_t;	// Seat 0 or seat 1

	// Blind sizes in chips
	localparam chip_t SMALL_BLIND = 15'd100;
	localparam chip_t BIG_BLIND = 15'd200;

endpackage

`default_nettype wire

// ==== src/poker_table.sv ====
// Heads-up betting engine top level with control, chip bank, bet sizer and turn tracker
`timescale 1ns/1ps
`default_nettype none

module poker_table import poker_money_pkg::*, poker_flow_pkg::*;
#(
	parameter chip_t START_CHIPS = 15'd2000
)
(
	input logic clock,
	input logic resetn,
	input logic start,
	input logic action_valid,
	input action_t action,
	input logic showdown_valid,
	input winner_t showdown_winner,
	output logic action_ready,
	output logic showdown_ready,
	output seat_t to_act,
	output street_t street,
	output chip_t stack0,
	output chip_t stack1,
	output chip_t bet0,
	output chip_t bet1,
	output chip_t pot,
	output logic hand_over,
	output logic match_over,
	output seat_t match_winner
);

	logic reset_chips, post_blinds, add_bet, collect, award;	// Chip strobes
	logic new_hand, new_street, acted;	// Turn strobes
	logic raised, round_done;
	winner_t award_result;
	chip_t bet_amount;
	seat_t big_blind_seat;

	betting_control u_control (
		.clock(clock), .resetn(resetn), .start(start),
		.action_valid(action_valid), .action(action),
		.showdown_valid(showdown_valid), .showdown_winner(showdown_winner),
		.raised(raised), .round_done(round_done), .street(street), .to_act(to_act),
		.stack0(stack0), .stack1(stack1),
		.action_ready(action_ready), .showdown_ready(showdown_ready),
		.reset_chips(reset_chips), .post_blinds(post_blinds), .add_bet(add_bet),
		.collect(collect), .award(award), .award_result(award_result),
		.new_hand(new_hand), .new_street(new_street), .acted(acted),
		.hand_over(hand_over), .match_over(match_over), .match_winner(match_winner)
	);

	chip_bank #(.START_CHIPS(START_CHIPS)) u_bank (
		.clock(clock), .resetn(resetn), .reset_chips(reset_chips),
		.post_blinds(post_blinds), .big_blind_seat(big_blind_seat),
		.add_bet(add_bet), .bet_seat(to_act), .bet_amount(bet_amount),	// Actor pays
		.collect(collect), .award(award), .award_result(award_result),
		.stack0(stack0), .stack1(stack1), .bet0(bet0), .bet1(bet1), .pot(pot)
	);

	bet_sizer u_sizer (
		.action(action), .to_act(to_act),
		.stack0(stack0), .stack1(stack1), .bet0(bet0), .bet1(bet1),
		.bet_amount(bet_amount), .raised(raised)
	);

	turn_tracker u_turn (
		.clock(clock), .resetn(resetn),
		.new_hand(new_hand), .new_street(new_street), .acted(acted), .raised(raised),
		.big_blind_seat(big_blind_seat), .street(street), .to_act(to_act),
		.round_done(round_done)
	);

endmodule

`default_nettype wire

// ==== src/turn_tracker.sv ====
// To-play flags, street counter, blind rotation and seat to act
`timescale 1ns/1ps
`default_nettype none

module turn_tracker import poker_money_pkg::*, poker_flow_pkg::*;
(
	input logic clock,
	input logic resetn,
	input logic new_hand,	// With new_street, restarts the rotation
	input logic new_street,
	input logic acted,
	input logic raised,
	output seat_t big_blind_seat,
	output street_t street,
	output seat_t to_act,
	output logic round_done	// A non-raise by to_act closes the street
);

	logic [1:0] to_play;	// One flag per seat
	seat_t other;

	assign other = ~to_act;
	assign round_done = ~to_play[other];

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			to_play <= 2'b00;
			street <= ST_PREFLOP;
			big_blind_seat <= 1'b0;	// Flips to seat 1 on first hand
			to_act <= 1'b0;
		end
		else if (new_hand)
		begin
			big_blind_seat <= new_street ? 1'b0 : ~big_blind_seat;
			to_act <= big_blind_seat;	// Old big blind is new small blind
			to_play <= 2'b11;
			street <= ST_PREFLOP;
		end
		else if (new_street)	// Big blind leads after the flop
		begin
			to_act <= big_blind_seat;
			to_play <= 2'b11;
			if (street != ST_SHOWDOWN)
				street <= street_t'(street + 3'd1);
		end
		else if (acted)
		begin
			to_play[to_act] <= 1'b0;
			if (raised)
				to_play[other] <= 1'b1;
			if (raised || to_play[other])	// Opponent still owes an action
				to_act <= other;
		end
	end

endmodule

`default_nettype wire

// ==== include/poker_model.svh ====
// Reference model state and update functions for chips and turn order
`ifndef POKER_MODEL_SVH
`define POKER_MODEL_SVH

typedef struct {
	chip_t stack [2];
	chip_t bet [2];
	chip_t pot;
	logic [1:0] to_play;	// Per seat
	seat_t to_act;
	seat_t bb;	// Big blind seat
	street_t street;
} poker_model_t;

function automatic void load_start_chips(inout poker_model_t m, input chip_t start_chips);
	m.stack[0] = start_chips;
	m.stack[1] = start_chips;
	m.bet[0] = '0;
	m.bet[1] = '0;
	m.pot = '0;
	m.bb = 1'b0;	// Seat 1 after first flip
endfunction

function automatic void deal_new_hand(inout poker_model_t m);
	m.to_act = m.bb;	// Small blind leads preflop
	m.bb = ~m.bb;
	m.to_play = 2'b11;
	m.street = ST_PREFLOP;
	m.bet[m.bb] = (m.stack[m.bb] < BIG_BLIND) ? m.stack[m.bb] : BIG_BLIND;
	m.bet[~m.bb] = (m.stack[~m.bb] < SMALL_BLIND) ? m.stack[~m.bb] : SMALL_BLIND;
	m.stack[m.bb] = m.stack[m.bb] - m.bet[m.bb];
	m.stack[~m.bb] = m.stack[~m.bb] - m.bet[~m.bb];
endfunction

// Returns 1 when the action closes the street
function automatic logic apply_action(inout poker_model_t m, input action_t a);
	seat_t s;
	chip_t own, opp, cap, target, amt;
	logic up;
	s = m.to_act;
	own = m.bet[s];
	opp = m.bet[~s];
	up = 1'b0;
	amt = (opp > own) ? opp - own : '0;
	if (amt > m.stack[s])
		amt = m.stack[s];
	case (a)
		ACT_RAISE_2BB, ACT_RAISE_4BB, ACT_RAISE_6BB:
		begin
			target = (a == ACT_RAISE_2BB) ? chip_t'(2 * BIG_BLIND) :
				(a == ACT_RAISE_4BB) ? chip_t'(4 * BIG_BLIND) : chip_t'(6 * BIG_BLIND);
			if (target > own && target > opp && own + m.stack[s] >= target &&
				opp + m.stack[~s] >= target)
			begin
				amt = target - own;
				up = 1'b1;
			end
		end
		ACT_ALL_IN:
		begin
			cap = (own + m.stack[s] < opp + m.stack[~s]) ?
				own + m.stack[s] : opp + m.stack[~s];
			amt = (cap > own) ? cap - own : '0;
			up = (cap > opp);
		end
		ACT_FOLD: return 1'b0;	// Award handled at hand end
		default: ;
	endcase
	m.stack[s] = m.stack[s] - amt;
	m.bet[s] = m.bet[s] + amt;
	m.to_play[s] = 1'b0;
	if (up)
		m.to_play[~s] = 1'b1;
	if (!m.to_play[~s])
		return 1'b1;
	m.to_act = ~s;
	return 1'b0;
endfunction

function automatic void close_street(inout poker_model_t m);
	m.pot = m.pot + m.bet[0] + m.bet[1];
	m.bet[0] = '0;
	m.bet[1] = '0;
	m.to_act = m.bb;
	m.to_play = 2'b11;
	if (m.street != ST_SHOWDOWN)
		m.street = street_t'(m.street + 3'd1);
endfunction

function automatic void pay_out_pot(inout poker_model_t m, input winner_t w);
	chip_t total;
	chip_t share0;
	total = m.pot + m.bet[0] + m.bet[1];
	m.pot = '0;
	m.bet[0] = '0;
	m.bet[1] = '0;
	case (w)
		WIN_SEAT0: m.stack[0] = m.stack[0] + total;
		WIN_SEAT1: m.stack[1] = m.stack[1] + total;
		default:
		begin
			share0 = (total + 15'd1) >> 1;	// Odd chip to seat 0
			m.stack[0] = m.stack[0] + share0;
			m.stack[1] = m.stack[1] + (total - share0);
		end
	endcase
endfunction

`endif

// ==== tb/poker_table_tb.sv ====
// Testbench for the heads-up betting engine with random play, reference model checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module poker_table_tb import poker_money_pkg::*, poker_flow_pkg::*;
();

	localparam chip_t START_CHIPS = 15'd2000;
	localparam int NUM_MATCHES = 3;
	localparam int MAX_HANDS = 200;	// Per match
	localparam int HAND_CYCLES = 400;	// Upper bound for one hand
	localparam int WATCHDOG_NS = NUM_MATCHES * MAX_HANDS * HAND_CYCLES * 100;

	logic clock, resetn, start;
	logic action_valid, showdown_valid;
	action_t action;
	winner_t showdown_winner;
	logic action_ready, showdown_ready, hand_over, match_over;
	seat_t to_act, match_winner;
	street_t street;
	chip_t stack0, stack1, bet0, bet1, pot;

	logic [31:0] seed;	// LCG state
	logic live;	// Chips on the table
	int match_idx;

	`include "poker_model.svh"

	poker_model_t m;	// Expected table

	poker_table #(.START_CHIPS(START_CHIPS)) UUT (
		.clock(clock), .resetn(resetn), .start(start),
		.action_valid(action_valid), .action(action),
		.showdown_valid(showdown_valid), .showdown_winner(showdown_winner),
		.action_ready(action_ready), .showdown_ready(showdown_ready),
		.to_act(to_act), .street(street),
		.stack0(stack0), .stack1(stack1), .bet0(bet0), .bet1(bet1), .pot(pot),
		.hand_over(hand_over), .match_over(match_over), .match_winner(match_winner)
	);

	initial clock = 1'b0;
	always #50 clock = ~clock;	// 100 ns period

	task automatic abort_run(input string why);
		$display("Error: %s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input int expected, input int actual);
		assert (expected == actual)
		else
		begin
			$display("Mismatch %s expected %0d actual %0d", name, expected, actual);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	function automatic logic [31:0] next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int rand_below(input int n);
		return int'(next_random() >> 8) % n;	// Low bits are weak
	endfunction

	function automatic action_t pick_action();
		int r;
		r = rand_below(10);
		if (r >= 7)	// Heavy all-in bias ends matches
			return ACT_ALL_IN;
		return action_t'(r);
	endfunction

	task automatic compare_with_model(input string tag);
		check_equal({tag, " stack0"}, int'(m.stack[0]), int'(stack0));
		check_equal({tag, " stack1"}, int'(m.stack[1]), int'(stack1));
		check_equal({tag, " bet0"}, int'(m.bet[0]), int'(bet0));
		check_equal({tag, " bet1"}, int'(m.bet[1]), int'(bet1));
		check_equal({tag, " pot"}, int'(m.pot), int'(pot));
		check_equal({tag, " to_act"}, int'(m.to_act), int'(to_act));
		check_equal({tag, " street"}, int'(m.street), int'(street));
	endtask

	task automatic settle_showdown();
		winner_t w;
		w = winner_t'(rand_below(3));	// Tie, seat 0 or seat 1
		repeat (rand_below(3)) @(negedge clock);
		showdown_winner = w;
		showdown_valid = 1'b1;
		while (!showdown_ready) @(negedge clock);
		compare_with_model("showdown");
		@(negedge clock);	// Result taken
		showdown_valid = 1'b0;
		pay_out_pot(m, w);
	endtask

	task automatic play_hand();
		action_t a;
		logic closes;
		forever
		begin
			a = pick_action();
			repeat (rand_below(3)) @(negedge clock);	// Valid may lead ready
			action = a;
			action_valid = 1'b1;
			while (!action_ready) @(negedge clock);
			compare_with_model("before action");
			@(negedge clock);	// Transfer on the posedge just passed
			action_valid = 1'b0;
			if (a == ACT_FOLD)
			begin
				pay_out_pot(m, m.to_act ? WIN_SEAT0 : WIN_SEAT1);
				break;
			end
			closes = apply_action(m, a);
			compare_with_model("after action");
			if (closes)
			begin
				close_street(m);
				if (m.street == ST_SHOWDOWN)
				begin
					settle_showdown();
					break;
				end
			end
		end
		while (!hand_over) @(negedge clock);
		compare_with_model("hand over");
	endtask

	task automatic run_match();
		int hands;
		logic over;
		hands = 0;
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		@(negedge clock);	// Two cycles after start
		check_equal("start stack0", int'(START_CHIPS), int'(stack0));
		check_equal("start stack1", int'(START_CHIPS), int'(stack1));
		load_start_chips(m, START_CHIPS);
		live = 1'b1;
		forever
		begin
			while (!action_ready && !match_over) @(negedge clock);
			over = (m.stack[0] == '0) || (m.stack[1] == '0);
			check_equal("match over", int'(over), int'(match_over));
			if (match_over)
			begin
				check_equal("match winner", int'(m.stack[0] == '0), int'(match_winner));
				break;
			end
			assert (hands < MAX_HANDS)
			else abort_run("match did not end within the hand limit");
			deal_new_hand(m);
			compare_with_model("blinds");
			play_hand();
			hands++;
		end
		@(negedge clock);
	endtask

	// Chips are never created or lost
	always @(negedge clock)
	begin
		if (live)
			check_equal("chip total", 2 * int'(START_CHIPS),
				int'(stack0) + int'(stack1) + int'(bet0) + int'(bet1) + int'(pot));
	end

	initial
	begin
		seed = 32'h4e56_f343;
		live = 1'b0;
		resetn = 1'b0;
		start = 1'b0;
		action_valid = 1'b0;
		action = ACT_CHECK;
		showdown_valid = 1'b0;
		showdown_winner = WIN_TIE;
		repeat (3) @(negedge clock);
		resetn = 1'b1;
		check_equal("reset flags", 0,
			int'({action_ready, showdown_ready, hand_over, match_over}));
		check_equal("reset chips", 0,
			int'(stack0) + int'(stack1) + int'(bet0) + int'(bet1) + int'(pot));
		for (match_idx = 0; match_idx < NUM_MATCHES; match_idx++)
			run_match();	// Later matches test restart
		$display("Test OK");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		abort_run("watchdog expired, the DUT stopped responding");
	end

endmodule

`default_nettype wire
